/* dbg_pkg.sv */
package dbg_pkg;

   // flit = 2 type bits + 16 data bits
   localparam int dbg_flit_width = 18;
   localparam int dbg_flit_data_width = 16;

   localparam logic [1:0] dbg_flit_type_head = 2'b01;
   localparam logic [1:0] dbg_flit_type_body = 2'b00;
   localparam logic [1:0] dbg_flit_type_tail = 2'b10;
   localparam logic [1:0] dbg_flit_type_single = 2'b11;

   // head flit data: dest | class | source id
   localparam int dbg_dest_width = 5;
   localparam int dbg_class_width = 3;
   localparam int dbg_id_width = 8;
   localparam logic [2:0] dbg_class_conf = 3'b111;

   // network and system
   localparam int dbg_vchannels = 2;
   localparam int dbg_conf_vchannel = 0;
   localparam logic [4:0] dbg_tcm_id = 5'd1;
   localparam logic [15:0] dbg_system_identifier = 16'hd0c5;
   localparam logic [15:0] dbg_module_count = 16'd1;
   localparam logic [15:0] dbg_tcm_version = 16'h0100;

   // configuration memory, 16 bit words
   localparam int conf_mem_size = 8;
   localparam int conf_addr_width = 3;
   localparam logic [conf_addr_width-1:0] conf_addr_ctrl = 3'd3;
   localparam logic [conf_addr_width-1:0] conf_addr_halt_hi = 3'd4;
   localparam logic [conf_addr_width-1:0] conf_addr_halt_lo = 3'd5;
   localparam logic [conf_addr_width-1:0] conf_addr_clk_hi = 3'd6;
   localparam logic [conf_addr_width-1:0] conf_addr_clk_lo = 3'd7;

   // control word bits
   localparam int ctrl_bit_stall = 0;
   localparam int ctrl_bit_unstall = 1;
   localparam int ctrl_bit_reset = 2;
   localparam int ctrl_bit_snapshot = 3;
   localparam int ctrl_bit_start = 4;

   // bit 15 of the address flit
   localparam logic conf_op_write = 1'b1;

   // reset image, word 0 in the low bits
   localparam logic [conf_mem_size*16-1:0] conf_mem_reset = {
      {(5*16){1'b0}}, dbg_module_count, dbg_system_identifier, dbg_tcm_version};

endpackage

/* dbgnoc_flit_buffer.sv */
`timescale 1ns/1ps

module dbgnoc_flit_buffer
   import dbg_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic [dbg_flit_width-1:0] in_flit,
   input  logic                      in_valid,
   output logic                      in_ready,
   output logic [dbg_flit_width-1:0] out_flit,
   output logic                      out_valid,
   input  logic                      out_ready
);

   logic [dbg_flit_width-1:0] entry [2]; // two flit slots
   logic                      wr_ptr;
   logic                      rd_ptr;
   logic [1:0]                count;
   logic [1:0]                count_next;
   logic                      push;
   logic                      pop;

   assign push = in_valid & in_ready;
   assign pop = out_valid & out_ready;

   // head of queue straight from the slot
   assign out_valid = (count != 2'd0);
   assign out_flit = entry[rd_ptr];

   // push and pop in one cycle keep the count
   assign count_next = count + {1'b0, push} - {1'b0, pop};

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= 2'd0;
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         in_ready <= 1'b0; // held low in reset
      end else begin
         count <= count_next;
         in_ready <= (count_next != 2'd2); // registered, no path from out_ready
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entry[wr_ptr] <= in_flit;
      end
   end

endmodule

/* dbgnoc_conf_if.sv */
`timescale 1ns/1ps

module dbgnoc_conf_if
   import dbg_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [dbg_flit_width-1:0]       in_flit,
   input  logic                            in_valid,
   output logic                            in_ready,
   output logic [dbg_flit_width-1:0]       out_flit,
   output logic                            out_valid,
   input  logic                            out_ready,
   output logic [conf_mem_size*16-1:0]     conf_mem_out,
   input  logic [conf_mem_size*16-1:0]     conf_mem_in,
   input  logic [conf_mem_size-1:0]        conf_mem_in_valid,
   output logic                            conf_mem_in_ack
);

   typedef enum logic [2:0] {
      st_idle,
      st_addr,
      st_data,
      st_resp_head,
      st_resp_addr,
      st_resp_data
   } state_t;

   state_t                         state;
   logic [1:0]                     in_type;
   logic [dbg_flit_data_width-1:0] in_data;
   logic                           take;
   logic                           pkt_end;
   logic                           net_wr;
   logic                           req_ok;    // addressed to us, conf class
   logic                           req_write;
   logic [dbg_dest_width-1:0]      req_src;   // becomes response dest
   logic [conf_addr_width-1:0]     req_addr;
   logic [15:0]                    rd_data;   // held for the whole response
   logic [15:0]                    mem [conf_mem_size];

   assign in_type = in_flit[dbg_flit_width-1 -: 2];
   assign in_data = in_flit[dbg_flit_data_width-1:0];

   // no new request while a response is pending
   assign in_ready = (state == st_idle) || (state == st_addr) || (state == st_data);
   assign take = in_valid & in_ready;
   assign pkt_end = (in_type == dbg_flit_type_tail) || (in_type == dbg_flit_type_single);

   // tail of a write, words below the control word are read-only
   assign net_wr = take && (state == st_data) && pkt_end && req_ok && req_write &&
                   (req_addr >= conf_addr_ctrl);
   assign conf_mem_in_ack = net_wr & conf_mem_in_valid[req_addr]; // local write lost

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (take && (in_type == dbg_flit_type_head)) begin
                  state <= st_addr;
               end
            end
            st_addr: begin
               if (take) begin
                  if (pkt_end) begin
                     state <= req_ok ? st_resp_head : st_idle; // read request
                  end else if (in_type == dbg_flit_type_body) begin
                     state <= st_data;
                  end else begin
                     state <= st_idle; // stray head, drop packet
                  end
               end
            end
            st_data: begin
               if (take && (in_type != dbg_flit_type_body)) begin
                  state <= st_idle;
               end
            end
            st_resp_head: if (out_ready) state <= st_resp_addr;
            st_resp_addr: if (out_ready) state <= st_resp_data;
            st_resp_data: if (out_ready) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // request fields
   always_ff @(posedge clk) begin
      if (take && (state == st_idle)) begin
         req_src <= in_data[dbg_dest_width-1:0];
         req_ok <= (in_data[15 -: dbg_dest_width] == dbg_tcm_id) &&
                   (in_data[dbg_id_width +: dbg_class_width] == dbg_class_conf);
      end
      if (take && (state == st_addr)) begin
         req_addr <= in_data[conf_addr_width-1:0];
         req_write <= (in_data[15] == conf_op_write) && !pkt_end;
         rd_data <= mem[in_data[conf_addr_width-1:0]]; // sampled at request
      end
   end

   // config memory, network write beats local write
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < conf_mem_size; i++) begin
            mem[i] <= conf_mem_reset[i*16 +: 16];
         end
      end else begin
         for (int i = 0; i < conf_mem_size; i++) begin
            if (net_wr && (req_addr == conf_addr_width'(i))) begin
               mem[i] <= in_data;
            end else if (conf_mem_in_valid[i]) begin
               mem[i] <= conf_mem_in[i*16 +: 16];
            end
         end
      end
   end

   for (genvar i = 0; i < conf_mem_size; i++) begin : g_mem_out
      assign conf_mem_out[i*16 +: 16] = mem[i];
   end

   // response: head back to requester, addr, data word
   assign out_valid = (state == st_resp_head) || (state == st_resp_addr) ||
                      (state == st_resp_data);

   always_comb begin
      out_flit = {dbg_flit_type_tail, rd_data};
      if (state == st_resp_head) begin
         out_flit = {dbg_flit_type_head, req_src, dbg_class_conf,
                     {(dbg_id_width-dbg_dest_width){1'b0}}, dbg_tcm_id};
      end else if (state == st_resp_addr) begin
         out_flit = {dbg_flit_type_body, {(dbg_flit_data_width-conf_addr_width){1'b0}},
                     req_addr};
      end
   end

endmodule

/* tcm.sv */
`timescale 1ns/1ps

module tcm
   import dbg_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      sys_clk_is_halted,
   input  logic [dbg_flit_width-1:0] net_in_flit,
   input  logic [dbg_vchannels-1:0]  net_in_valid,
   output logic [dbg_vchannels-1:0]  net_in_ready,
   output logic [dbg_flit_width-1:0] net_out_flit,
   output logic [dbg_vchannels-1:0]  net_out_valid,
   input  logic [dbg_vchannels-1:0]  net_out_ready,
   output logic                      cpu_stall,
   output logic                      cpu_reset,
   output logic                      start_cpu
);

   logic                        conf_in_ready;
   logic                        conf_out_valid;
   logic [dbg_flit_width-1:0]   req_flit;   // inbound buffer -> conf_if
   logic                        req_valid;
   logic                        req_ready;
   logic [dbg_flit_width-1:0]   resp_flit;  // conf_if -> outbound buffer
   logic                        resp_valid;
   logic                        resp_ready;
   logic [conf_mem_size*16-1:0] conf_mem_out;
   logic [conf_mem_size*16-1:0] conf_mem_in;
   logic [conf_mem_size-1:0]    conf_mem_in_valid;
   logic                        conf_mem_in_ack;
   logic [15:0]                 ctrl_word;
   logic [31:0]                 halt_cnt;
   logic [31:0]                 clk_cnt;
   logic [31:0]                 snap_halt;  // kept in case the write is lost
   logic [31:0]                 snap_clk;
   logic                        snap_retry;
   logic                        snap_now;
   logic [31:0]                 halt_word;
   logic [31:0]                 clk_word;

   // other channel always ready, its flits vanish
   assign net_in_ready = ~(dbg_vchannels'(1) << dbg_conf_vchannel) |
                         (dbg_vchannels'(conf_in_ready) << dbg_conf_vchannel);
   assign net_out_valid = dbg_vchannels'(conf_out_valid) << dbg_conf_vchannel;

   dbgnoc_flit_buffer u_in_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (net_in_flit),
      .in_valid  (net_in_valid[dbg_conf_vchannel]),
      .in_ready  (conf_in_ready),
      .out_flit  (req_flit),
      .out_valid (req_valid),
      .out_ready (req_ready)
   );

   dbgnoc_conf_if u_conf_if (
      .clk               (clk),
      .rst               (rst),
      .in_flit           (req_flit),
      .in_valid          (req_valid),
      .in_ready          (req_ready),
      .out_flit          (resp_flit),
      .out_valid         (resp_valid),
      .out_ready         (resp_ready),
      .conf_mem_out      (conf_mem_out),
      .conf_mem_in       (conf_mem_in),
      .conf_mem_in_valid (conf_mem_in_valid),
      .conf_mem_in_ack   (conf_mem_in_ack)
   );

   dbgnoc_flit_buffer u_out_buf (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (resp_flit),
      .in_valid  (resp_valid),
      .in_ready  (resp_ready),
      .out_flit  (net_out_flit),
      .out_valid (conf_out_valid),
      .out_ready (net_out_ready[dbg_conf_vchannel])
   );

   assign ctrl_word = conf_mem_out[conf_addr_ctrl*16 +: 16];

   // snapshot goes out now, or again from the saved copy after a loss
   assign snap_now = ctrl_word[ctrl_bit_snapshot] | snap_retry;
   assign halt_word = snap_retry ? snap_halt : halt_cnt;
   assign clk_word = snap_retry ? snap_clk : clk_cnt;

   always_comb begin
      conf_mem_in = '0; // control word written back as zero
      conf_mem_in[conf_addr_halt_hi*16 +: 16] = halt_word[31:16];
      conf_mem_in[conf_addr_halt_lo*16 +: 16] = halt_word[15:0];
      conf_mem_in[conf_addr_clk_hi*16 +: 16] = clk_word[31:16];
      conf_mem_in[conf_addr_clk_lo*16 +: 16] = clk_word[15:0];
      conf_mem_in_valid = '0;
      conf_mem_in_valid[conf_addr_ctrl] = |ctrl_word; // clear once acted on
      conf_mem_in_valid[conf_addr_halt_hi] = snap_now;
      conf_mem_in_valid[conf_addr_halt_lo] = snap_now;
      conf_mem_in_valid[conf_addr_clk_hi] = snap_now;
      conf_mem_in_valid[conf_addr_clk_lo] = snap_now;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         cpu_stall <= 1'b0;
         cpu_reset <= 1'b0;
         start_cpu <= 1'b0;
         snap_retry <= 1'b0;
         halt_cnt <= '0;
         clk_cnt <= '0;
      end else begin
         if (ctrl_word[ctrl_bit_unstall]) begin
            cpu_stall <= 1'b0; // unstall wins over stall
         end else if (ctrl_word[ctrl_bit_stall]) begin
            cpu_stall <= 1'b1;
         end
         cpu_reset <= ctrl_word[ctrl_bit_reset]; // word cleared, so one cycle
         start_cpu <= ctrl_word[ctrl_bit_start];
         snap_retry <= snap_now & conf_mem_in_ack;
         if (ctrl_word[ctrl_bit_snapshot]) begin
            halt_cnt <= '0;
            clk_cnt <= '0;
         end else begin
            if (clk_cnt != '1) begin
               clk_cnt <= clk_cnt + 32'd1; // saturating
            end
            if (sys_clk_is_halted && (halt_cnt != '1)) begin
               halt_cnt <= halt_cnt + 32'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_word[ctrl_bit_snapshot]) begin
         snap_halt <= halt_cnt;
         snap_clk <= clk_cnt;
      end
   end

endmodule

/* dbg_subsystem_top.sv */
`timescale 1ns/1ps

module dbg_subsystem_top
   import dbg_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      sys_clk_is_halted,
   input  logic [dbg_flit_width-1:0] net_in_flit,
   input  logic [dbg_vchannels-1:0]  net_in_valid,
   output logic [dbg_vchannels-1:0]  net_in_ready,
   output logic [dbg_flit_width-1:0] net_out_flit,
   output logic [dbg_vchannels-1:0]  net_out_valid,
   input  logic [dbg_vchannels-1:0]  net_out_ready,
   output logic                      cpu_stall,
   output logic                      cpu_reset,
   output logic                      start_cpu
);

   // trace controller, only debug module so far
   tcm u_tcm (
      .clk               (clk),
      .rst               (rst),
      .sys_clk_is_halted (sys_clk_is_halted),
      .net_in_flit       (net_in_flit),
      .net_in_valid      (net_in_valid),
      .net_in_ready      (net_in_ready),
      .net_out_flit      (net_out_flit),
      .net_out_valid     (net_out_valid),
      .net_out_ready     (net_out_ready),
      .cpu_stall         (cpu_stall),
      .cpu_reset         (cpu_reset),
      .start_cpu         (start_cpu)
   );

endmodule

/* dbg_assertions.sv */
`timescale 1ns/1ps

module dbg_assertions
   import dbg_pkg::*;
(
   input logic                     clk,
   input logic                     rst,
   input logic                     cpu_reset,
   input logic                     start_cpu,
   input logic [dbg_vchannels-1:0] net_out_valid,
   input logic [dbg_vchannels-1:0] net_in_ready
);

   // control pulses last exactly one cycle
   a_reset_pulse: assert property (@(posedge clk) disable iff (rst) cpu_reset |=> !cpu_reset)
      else $error("cpu_reset stayed high for two cycles");

   a_start_pulse: assert property (@(posedge clk) disable iff (rst) start_cpu |=> !start_cpu)
      else $error("start_cpu stayed high for two cycles");

   // responses only ever leave on the config channel
   a_no_out_vc1: assert property (@(posedge clk) disable iff (rst) !net_out_valid[1])
      else $error("net_out_valid set on channel 1");

   // dropped channel never back-pressures
   a_vc1_ready: assert property (@(posedge clk) !rst |-> net_in_ready[1])
      else $error("net_in_ready low on channel 1 outside reset");

endmodule

bind tcm dbg_assertions u_dbg_assertions (.*);

/* tb_dbg.sv */
`timescale 1ns/1ps

module tb_dbg
   import dbg_pkg::*;
;

   localparam int max_cases = 64;
   localparam logic [7:0] host_id = 8'h0a; // our source id in requests

   logic                      clk;
   logic                      rst;
   logic                      sys_clk_is_halted;
   logic [dbg_flit_width-1:0] net_in_flit;
   logic [dbg_vchannels-1:0]  net_in_valid;
   logic [dbg_vchannels-1:0]  net_in_ready;
   logic [dbg_flit_width-1:0] net_out_flit;
   logic [dbg_vchannels-1:0]  net_out_valid;
   logic [dbg_vchannels-1:0]  net_out_ready;
   logic                      cpu_stall;
   logic                      cpu_reset;
   logic                      start_cpu;

   reg [8*24-1:0] case_name [max_cases];
   reg [8*8-1:0]  case_op [max_cases];
   logic [15:0]   case_addr [max_cases];
   logic [15:0]   case_data [max_cases];
   logic [15:0]   case_exp [max_cases];
   int            n_cases;
   reg [8*24-1:0] cur_name;
   int            errors;
   int            test_errs;
   int            passed;
   int            failed;
   int            cycles;
   int            cycle_limit;
   int            reset_pulses;
   int            start_pulses;
   logic [dbg_flit_width-1:0] rx_q [$]; // flits seen on net_out
   logic          bp_en;
   logic [31:0]   lcg_state;
   logic [31:0]   prev_total;

   dbg_subsystem_top dut0 (
      .clk               (clk),
      .rst               (rst),
      .sys_clk_is_halted (sys_clk_is_halted),
      .net_in_flit       (net_in_flit),
      .net_in_valid      (net_in_valid),
      .net_in_ready      (net_in_ready),
      .net_out_flit      (net_out_flit),
      .net_out_valid     (net_out_valid),
      .net_out_ready     (net_out_ready),
      .cpu_stall         (cpu_stall),
      .cpu_reset         (cpu_reset),
      .start_cpu         (start_cpu)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // random ready on the config channel when back-pressure is on
   always @(negedge clk) begin
      lcg_state = lcg_next(lcg_state);
      net_out_ready[0] = bp_en ? lcg_state[16] : 1'b1;
      net_out_ready[1] = 1'b1;
   end

   // response collector and pulse counters
   always @(posedge clk) begin
      if (!rst) begin
         if (net_out_valid[0] && net_out_ready[0]) begin
            rx_q.push_back(net_out_flit);
         end
         if (cpu_reset) reset_pulses++;
         if (start_cpu) start_pulses++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: run went past %0d cycles", cycle_limit);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check_val(input logic [31:0] exp, input logic [31:0] act,
                            input string what);
      assert (exp == act) else begin
         $display("ERR %0s %0s expected %h actual %h", cur_name, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic load_cases();
      int fd;
      int n;
      string line;
      reg [8*24-1:0] nm;
      reg [8*8-1:0] op;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] e;
      n_cases = 0;
      fd = $fopen("dbg_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open the case file dbg_cases.txt");
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin // skip comments and blank lines
            n = $sscanf(line, "%s %s %h %h %h", nm, op, a, d, e);
            if (n == 5 && n_cases < max_cases) begin
               case_name[n_cases] = nm;
               case_op[n_cases] = op;
               case_addr[n_cases] = a;
               case_data[n_cases] = d;
               case_exp[n_cases] = e;
               n_cases++;
            end
         end
      end
      $fclose(fd);
   endtask

   // starts and ends on a falling edge
   task automatic send_flit(input int ch, input logic [dbg_flit_width-1:0] f);
      logic acc;
      acc = 1'b0;
      net_in_flit = f;
      net_in_valid = (ch == 1) ? 2'b10 : 2'b01;
      while (!acc) begin
         acc = net_in_ready[ch]; // registered so stable here
         @(negedge clk);
      end
      net_in_valid = '0;
   endtask

   function automatic logic [dbg_flit_width-1:0] head_flit();
      return {dbg_flit_type_head, dbg_tcm_id, dbg_class_conf, host_id};
   endfunction

   task automatic write_word(input logic [2:0] addr, input logic [15:0] data);
      send_flit(0, head_flit());
      send_flit(0, {dbg_flit_type_body, 1'b1, 12'h000, addr});
      send_flit(0, {dbg_flit_type_tail, data});
   endtask

   task automatic read_word(input logic [2:0] addr, output logic [15:0] data);
      logic [dbg_flit_width-1:0] h;
      logic [dbg_flit_width-1:0] b;
      logic [dbg_flit_width-1:0] t;
      send_flit(0, head_flit());
      send_flit(0, {dbg_flit_type_tail, 1'b0, 12'h000, addr});
      while (rx_q.size() < 3) @(negedge clk); // wait for full response
      h = rx_q.pop_front();
      b = rx_q.pop_front();
      t = rx_q.pop_front();
      // head goes back to us with the controller as source
      check_val(32'({dbg_flit_type_head, host_id[4:0], dbg_class_conf, 3'b000, dbg_tcm_id}),
                32'(h), "resp head");
      check_val(32'({dbg_flit_type_body, 13'h0000, addr}), 32'(b), "resp addr");
      check_val(32'(dbg_flit_type_tail), 32'(t[17:16]), "resp tail type");
      data = t[15:0];
   endtask

   task automatic count_idle_pulses(input int n, input logic [15:0] exp);
      repeat (n) @(negedge clk);
      check_val(32'(exp[11:8]), 32'(reset_pulses), "cpu_reset pulses");
      check_val(32'(exp[7:4]), 32'(start_pulses), "start_cpu pulses");
      check_val(32'(exp[3:0]), 32'(cpu_stall), "cpu_stall");
      reset_pulses = 0;
      start_pulses = 0;
   endtask

   // a complete write and read on channel 1 must leave no trace
   task automatic drop_on_vc1(input logic [15:0] data);
      logic [15:0] kept;
      logic [15:0] rd;
      kept = ~data;
      write_word(conf_addr_halt_hi, kept); // known value in a writable word
      send_flit(1, head_flit());
      send_flit(1, {dbg_flit_type_body, 1'b1, 12'h000, conf_addr_halt_hi});
      send_flit(1, {dbg_flit_type_tail, data});
      send_flit(1, head_flit());
      send_flit(1, {dbg_flit_type_tail, 1'b0, 12'h000, conf_addr_halt_hi});
      repeat (10) begin
         @(negedge clk);
         assert (net_out_valid == '0 && rx_q.size() == 0) else begin
            $display("%0s: response seen after flits on channel 1", cur_name);
            test_errs++;
         end
      end
      read_word(conf_addr_halt_hi, rd);
      check_val(32'(kept), 32'(rd), "word 4 after channel 1 write");
   endtask

   // mode 0 halt zero, 1 halt equals total, 2 total below last, 3 no check
   task automatic snapshot_counters(input logic [15:0] mode);
      logic [15:0] w4;
      logic [15:0] w5;
      logic [15:0] w6;
      logic [15:0] w7;
      logic [31:0] halt;
      logic [31:0] total;
      write_word(conf_addr_ctrl, 16'h0001 << ctrl_bit_snapshot);
      read_word(conf_addr_halt_hi, w4);
      read_word(conf_addr_halt_lo, w5);
      read_word(conf_addr_clk_hi, w6);
      read_word(conf_addr_clk_lo, w7);
      halt = {w4, w5};
      total = {w6, w7};
      if (mode == 16'd0) check_val(32'd0, halt, "halt count");
      if (mode == 16'd1) check_val(total, halt, "halt count");
      if (mode == 16'd0 || mode == 16'd1) begin
         assert (total != 32'd0) else begin
            $display("%0s: total cycle count is zero", cur_name);
            test_errs++;
         end
      end
      if (mode == 16'd2) begin
         assert (total < prev_total) else begin
            $display("%0s: total %0d not below previous total %0d", cur_name, total,
                     prev_total);
            test_errs++;
         end
      end
      prev_total = total;
   endtask

   initial begin
      logic [15:0] rd;
      lcg_state = 32'd83;
      rst = 1'b1;
      sys_clk_is_halted = 1'b0;
      net_in_flit = '0;
      net_in_valid = '0;
      net_out_ready = 2'b11;
      bp_en = 1'b0;
      errors = 0;
      passed = 0;
      failed = 0;
      cycles = 0;
      cycle_limit = 100000;
      reset_pulses = 0;
      start_pulses = 0;
      prev_total = '0;
      load_cases();
      cycle_limit = 40 * n_cases + 200;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!cpu_stall && !cpu_reset && !start_cpu && net_out_valid == '0 &&
              net_in_ready == 2'b10) else begin
         $display("outputs or ready not at their reset values");
         errors++;
      end
      for (int i = 0; i < n_cases; i++) begin
         cur_name = case_name[i];
         test_errs = 0;
         if (case_op[i] == "wr") begin
            write_word(case_addr[i][2:0], case_data[i]);
         end else if (case_op[i] == "rd") begin
            read_word(case_addr[i][2:0], rd);
            check_val(32'(case_exp[i]), 32'(rd), "read data");
         end else if (case_op[i] == "halt") begin
            sys_clk_is_halted = case_data[i][0];
            @(negedge clk);
         end else if (case_op[i] == "idle") begin
            count_idle_pulses(int'(case_addr[i]), case_exp[i]);
         end else if (case_op[i] == "drop") begin
            drop_on_vc1(case_data[i]);
         end else if (case_op[i] == "bp") begin
            bp_en = case_addr[i][0];
         end else if (case_op[i] == "snap") begin
            snapshot_counters(case_addr[i]);
         end else begin
            $display("%0s: unknown operation in case file", cur_name);
            test_errs++;
         end
         $display("%0s: %0s", cur_name, (test_errs == 0) ? "ok" : "FAIL");
         if (test_errs == 0) passed++;
         else failed++;
         errors += test_errs;
      end
      $display("tests %0d passed %0d failed %0d errors %0d", n_cases, passed, failed, errors);
      if (errors == 0 && n_cases > 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* dbg_cases.txt */
# name op addr data expect (hex); ops wr rd halt idle drop bp snap
# idle expect = reset pulses, start pulses, stall; snap addr = check mode
ver_rd rd 0 0 0100
id_rd rd 1 0 d0c5
cnt_rd rd 2 0 0001
ver_wr wr 0 1234 0
ver_rd2 rd 0 0 0100
id_wr wr 1 ffff 0
id_rd2 rd 1 0 d0c5
cnt_wr wr 2 0 0
cnt_rd2 rd 2 0 0001
stall_wr wr 3 0001 0
stall_idle idle 8 0 001
stall_ctrl_rd rd 3 0 0
unstall_wr wr 3 0002 0
unstall_idle idle 8 0 000
both_wr wr 3 0003 0
both_idle idle 8 0 000
reset_wr wr 3 0004 0
reset_idle idle 6 0 100
reset_ctrl_rd rd 3 0 0
start_wr wr 3 0010 0
start_idle idle 6 0 010
start_ctrl_rd rd 3 0 0
halt_lo halt 0 0 0
snap_low snap 0 0 0
halt_hi halt 0 1 0
snap_restart snap 3 0 0
long_idle idle 30 0 000
snap_equal snap 1 0 0
snap_again snap 2 0 0
halt_off halt 0 0 0
drop_a drop 0 ffff 0
drop_b drop 0 8003 0
drop_ctrl_rd rd 3 0 0
drop_ver_rd rd 0 0 0100
bp_on bp 1 0 0
bp_rd0 rd 0 0 0100
bp_rd1 rd 1 0 d0c5
bp_rd2 rd 2 0 0001
bp_rd3 rd 3 0 0
bp_off bp 0 0 0

/* tb.f */
dbg_pkg.sv
dbgnoc_flit_buffer.sv
dbgnoc_conf_if.sv
tcm.sv
dbg_subsystem_top.sv
dbg_assertions.sv
tb_dbg.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dbg
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= tb.f
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
